// File: cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Cache geometry
`define CACHE_NUM_SETS          16
`define CACHE_LINE_WORDS        4
`define CACHE_WORD_BITS         32
`define CACHE_TAG_BITS          24
`define CACHE_INDEX_BITS        4

// Byte offset bits within a line, word select plus byte select
`define CACHE_LINE_OFFSET_BITS  4

// Backing line memory
`define MEM_NUM_LINES           256
`define MEM_LINE_ADDR_BITS      8

// Cycles from an accepted memory request to its completion
`define MEM_LATENCY             6

`endif

// File: cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

  typedef logic [`CACHE_WORD_BITS-1:0] word_t;

  // Word 0 sits in the low 32 bits of the line
  typedef word_t [`CACHE_LINE_WORDS-1:0] line_t;

  typedef struct packed {
    logic [`CACHE_TAG_BITS-1:0]   tag;
    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [1:0]                   word_off;
    logic [1:0]                   byte_off;
  } cache_addr_fields_t;

  // Request address, seen as a flat word or split into lookup fields
  typedef union packed {
    logic [31:0]        raw;
    cache_addr_fields_t f;
  } cache_addr_t;

  typedef enum logic [1:0] {
    idle        = 2'b00,
    compare_tag = 2'b01,
    write_back  = 2'b10,
    allocate    = 2'b11
  } cache_state_t;

endpackage

// File: cache_arrays.sv
`include "cache_cfg.svh"

module cache_arrays (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`CACHE_INDEX_BITS-1:0]  lookup_index,
  input  logic                          line_we,
  input  cache_pkg::line_t              line_wdata,
  input  logic                          meta_we,
  input  logic [`CACHE_TAG_BITS-1:0]    meta_tag,
  input  logic                          meta_dirty,
  output cache_pkg::line_t              rd_line,
  output logic [`CACHE_TAG_BITS-1:0]    rd_tag,
  output logic                          rd_valid,
  output logic                          rd_dirty
);

  import cache_pkg::*;

  // Data bank and tag table, one entry per set
  line_t                       data_bank [`CACHE_NUM_SETS];
  logic [`CACHE_TAG_BITS-1:0]  tag_bank  [`CACHE_NUM_SETS];

  // Status bits kept as vectors so reset clears them in one step
  logic [`CACHE_NUM_SETS-1:0]  valid_bits;
  logic [`CACHE_NUM_SETS-1:0]  dirty_bits;

  // Combinational read of the selected set
  assign rd_line  = data_bank[lookup_index];
  assign rd_tag   = tag_bank[lookup_index];
  assign rd_valid = valid_bits[lookup_index];
  assign rd_dirty = dirty_bits[lookup_index];

  always_ff @(posedge clk) begin
    if (line_we) begin
      data_bank[lookup_index] <= line_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (meta_we) begin
      tag_bank[lookup_index] <= meta_tag;
    end
  end

  // Any metadata write leaves the set valid
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (meta_we) begin
      valid_bits[lookup_index] <= 1'b1;
      dirty_bits[lookup_index] <= meta_dirty;
    end
  end

endmodule

// File: cache_ctrl.sv
`include "cache_cfg.svh"

module cache_ctrl (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             req_valid,
  input  logic                             req_write,
  input  cache_pkg::cache_addr_t           req_addr,
  input  cache_pkg::word_t                 req_wdata,
  output logic                             req_ready,
  output logic                             resp_valid,
  output cache_pkg::word_t                 resp_rdata,
  output logic                             resp_hit,
  output logic [`CACHE_INDEX_BITS-1:0]     lookup_index,
  output logic                             line_we,
  output cache_pkg::line_t                 line_wdata,
  output logic                             meta_we,
  output logic [`CACHE_TAG_BITS-1:0]       meta_tag,
  output logic                             meta_dirty,
  input  cache_pkg::line_t                 rd_line,
  input  logic [`CACHE_TAG_BITS-1:0]       rd_tag,
  input  logic                             rd_valid,
  input  logic                             rd_dirty,
  output logic                             mem_req_valid,
  output logic                             mem_req_write,
  output logic [`MEM_LINE_ADDR_BITS-1:0]   mem_req_line,
  output cache_pkg::line_t                 mem_req_wdata,
  input  logic                             mem_req_ready,
  input  logic                             mem_resp_valid,
  input  cache_pkg::line_t                 mem_resp_rdata
);

  import cache_pkg::*;

  cache_state_t  state;

  // Accepted request
  cache_addr_t   addr_q;
  logic          write_q;
  word_t         wdata_q;
  logic          missed_q;

  // Write hit held for one cycle, lands on the edge after the response
  logic          hit_wr_pend;
  line_t         hit_line_q;

  logic          hit;
  logic          victim_dirty;
  logic          issue_refill;
  line_t         merged_line;
  logic [`CACHE_TAG_BITS+`CACHE_INDEX_BITS-1:0] victim_line;
  logic [`MEM_LINE_ADDR_BITS-1:0]               fetch_line;

  assign req_ready    = (state == idle);
  assign lookup_index = addr_q.f.index;
  assign hit          = rd_valid && (rd_tag == addr_q.f.tag);
  assign victim_dirty = rd_valid && rd_dirty;

  // Victim line address comes from the stored tag, refill from the request
  assign victim_line  = {rd_tag, addr_q.f.index};
  assign fetch_line   = addr_q.raw[`CACHE_LINE_OFFSET_BITS +: `MEM_LINE_ADDR_BITS];

  // Start the refill once the write-back has been taken and has finished
  assign issue_refill = (state == write_back) && !mem_req_valid && mem_req_ready;

  always_comb begin
    merged_line = rd_line;
    merged_line[addr_q.f.word_off] = wdata_q;
  end

  // Array updates, refill from memory or a deferred write hit
  always_comb begin
    line_we    = 1'b0;
    meta_we    = 1'b0;
    line_wdata = hit_line_q;
    meta_tag   = addr_q.f.tag;
    meta_dirty = 1'b0;
    if ((state == allocate) && mem_resp_valid) begin
      line_we    = 1'b1;
      meta_we    = 1'b1;
      line_wdata = mem_resp_rdata;
    end else if (hit_wr_pend) begin
      line_we    = 1'b1;
      meta_we    = 1'b1;
      meta_dirty = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= idle;
      resp_valid    <= 1'b0;
      resp_hit      <= 1'b0;
      missed_q      <= 1'b0;
      hit_wr_pend   <= 1'b0;
      mem_req_valid <= 1'b0;
      mem_req_write <= 1'b0;
    end else begin
      resp_valid  <= 1'b0;
      hit_wr_pend <= 1'b0;
      if (mem_req_valid && mem_req_ready) begin
        mem_req_valid <= 1'b0;
      end
      case (state)
        idle: begin
          if (req_valid) begin
            missed_q <= 1'b0;
            state    <= compare_tag;
          end
        end
        compare_tag: begin
          if (hit) begin
            resp_valid  <= 1'b1;
            resp_hit    <= !missed_q;
            hit_wr_pend <= write_q;
            state       <= idle;
          end else begin
            missed_q      <= 1'b1;
            mem_req_valid <= 1'b1;
            mem_req_write <= victim_dirty;
            state         <= victim_dirty ? write_back : allocate;
          end
        end
        write_back: begin
          if (issue_refill) begin
            mem_req_valid <= 1'b1;
            mem_req_write <= 1'b0;
            state         <= allocate;
          end
        end
        allocate: begin
          // Refill written this cycle, repeat the lookup
          if (mem_resp_valid) begin
            state <= compare_tag;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_ready) begin
      addr_q  <= req_addr;
      write_q <= req_write;
      wdata_q <= req_wdata;
    end
    if (state == compare_tag) begin
      resp_rdata    <= rd_line[addr_q.f.word_off];
      hit_line_q    <= merged_line;
      mem_req_wdata <= rd_line;
      mem_req_line  <= victim_dirty ? victim_line[`MEM_LINE_ADDR_BITS-1:0] : fetch_line;
    end else if (issue_refill) begin
      mem_req_line  <= fetch_line;
    end
  end

endmodule

// File: line_memory.sv
`include "cache_cfg.svh"

module line_memory (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            mem_req_valid,
  input  logic                            mem_req_write,
  input  logic [`MEM_LINE_ADDR_BITS-1:0]  mem_req_line,
  input  cache_pkg::line_t                mem_req_wdata,
  output logic                            mem_req_ready,
  output logic                            mem_resp_valid,
  output cache_pkg::line_t                mem_resp_rdata
);

  import cache_pkg::*;

  localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

  line_t                           mem [`MEM_NUM_LINES];
  logic                            busy;
  logic                            rd_pend;
  logic [CNT_W-1:0]                count;
  logic [`MEM_LINE_ADDR_BITS-1:0]  line_q;
  logic                            accept;
  logic                            done;

  assign mem_req_ready = !busy;
  assign accept        = mem_req_valid && !busy;
  assign done          = busy && (count == '0);

  // Contents clear at reset, writes land when the request is taken
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `MEM_NUM_LINES; i++) begin
        mem[i] <= '0;
      end
    end else if (accept && mem_req_write) begin
      mem[mem_req_line] <= mem_req_wdata;
    end
  end

  // One access at a time, finishing MEM_LATENCY cycles after acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      busy           <= 1'b0;
      rd_pend        <= 1'b0;
      count          <= '0;
      mem_resp_valid <= 1'b0;
    end else begin
      mem_resp_valid <= 1'b0;
      if (accept) begin
        busy    <= 1'b1;
        rd_pend <= !mem_req_write;
        count   <= CNT_W'(`MEM_LATENCY - 1);
      end else if (done) begin
        busy           <= 1'b0;
        rd_pend        <= 1'b0;
        mem_resp_valid <= rd_pend;
      end else if (busy) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      line_q <= mem_req_line;
    end
    if (done) begin
      mem_resp_rdata <= mem[line_q];
    end
  end

endmodule

// File: cache_top.sv
`include "cache_cfg.svh"

module cache_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_valid,
  input  logic                    req_write,
  input  cache_pkg::cache_addr_t  req_addr,
  input  cache_pkg::word_t        req_wdata,
  output logic                    req_ready,
  output logic                    resp_valid,
  output cache_pkg::word_t        resp_rdata,
  output logic                    resp_hit
);

  import cache_pkg::*;

  // Controller to arrays
  logic [`CACHE_INDEX_BITS-1:0]    lookup_index;
  logic                            line_we;
  line_t                           line_wdata;
  logic                            meta_we;
  logic [`CACHE_TAG_BITS-1:0]      meta_tag;
  logic                            meta_dirty;
  line_t                           rd_line;
  logic [`CACHE_TAG_BITS-1:0]      rd_tag;
  logic                            rd_valid;
  logic                            rd_dirty;

  // Controller to line memory
  logic                            mem_req_valid;
  logic                            mem_req_write;
  logic [`MEM_LINE_ADDR_BITS-1:0]  mem_req_line;
  line_t                           mem_req_wdata;
  logic                            mem_req_ready;
  logic                            mem_resp_valid;
  line_t                           mem_resp_rdata;

  cache_ctrl u_ctrl (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_ready      (req_ready),
    .resp_valid     (resp_valid),
    .resp_rdata     (resp_rdata),
    .resp_hit       (resp_hit),
    .lookup_index   (lookup_index),
    .line_we        (line_we),
    .line_wdata     (line_wdata),
    .meta_we        (meta_we),
    .meta_tag       (meta_tag),
    .meta_dirty     (meta_dirty),
    .rd_line        (rd_line),
    .rd_tag         (rd_tag),
    .rd_valid       (rd_valid),
    .rd_dirty       (rd_dirty),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_line   (mem_req_line),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

  cache_arrays u_arrays (
    .clk          (clk),
    .reset        (reset),
    .lookup_index (lookup_index),
    .line_we      (line_we),
    .line_wdata   (line_wdata),
    .meta_we      (meta_we),
    .meta_tag     (meta_tag),
    .meta_dirty   (meta_dirty),
    .rd_line      (rd_line),
    .rd_tag       (rd_tag),
    .rd_valid     (rd_valid),
    .rd_dirty     (rd_dirty)
  );

  line_memory u_mem (
    .clk            (clk),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_write  (mem_req_write),
    .mem_req_line   (mem_req_line),
    .mem_req_wdata  (mem_req_wdata),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_rdata (mem_resp_rdata)
  );

endmodule

// File: tb_cache.sv
`include "cache_cfg.svh"

module tb_cache;

  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int CLK_PERIOD     = 8;
  localparam int NUM_REQUESTS   = 230;
  // Worst case per request is a dirty miss with one write and one read
  localparam int CYCLES_PER_REQ = 2 * `MEM_LATENCY + 10;
  localparam int WAIT_LIMIT     = 2 * CYCLES_PER_REQ;
  localparam int WATCHDOG_NS    = (NUM_REQUESTS * CYCLES_PER_REQ + 100) * CLK_PERIOD;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_write;
  cache_addr_t req_addr;
  word_t       req_wdata;
  logic        req_ready;
  logic        resp_valid;
  word_t       resp_rdata;
  logic        resp_hit;

  integer      seed;

  // Shadow of the memory contents and of the tag table
  word_t       shadow_mem   [1024];
  logic [23:0] shadow_tag   [`CACHE_NUM_SETS];
  logic        shadow_valid [`CACHE_NUM_SETS];

  cache_top dut (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_write  (req_write),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_rdata (resp_rdata),
    .resp_hit   (resp_hit)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic fail_run(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "Stopping at first error");
    end
  endtask

  // Hit when the set is valid with an equal tag
  // The set holds the new tag afterwards
  task automatic shadow_access(input logic write, input logic [31:0] addr, input word_t wdata,
                               output logic exp_hit, output word_t exp_data);
    logic [3:0]  idx;
    logic [23:0] tag;
    idx      = addr[7:4];
    tag      = addr[31:8];
    exp_hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
    exp_data = shadow_mem[addr[11:2]];
    if (write) begin
      shadow_mem[addr[11:2]] = wdata;
    end
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx]   = tag;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!req_ready) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("req_ready never returned high");
      end
    end
  endtask

  task automatic wait_response();
    int cycles;
    cycles = 0;
    while (!resp_valid) begin
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("timeout waiting for resp_valid");
      end
    end
  endtask

  task automatic do_request(input logic write, input logic [31:0] addr, input word_t wdata);
    logic  exp_hit;
    word_t exp_data;
    shadow_access(write, addr, wdata, exp_hit, exp_data);
    wait_ready();
    req_valid    = 1'b1;
    req_write    = write;
    req_addr.raw = addr;
    req_wdata    = wdata;
    next_cycle();
    req_valid = 1'b0;
    wait_response();
    check(resp_hit, exp_hit, $sformatf("resp_hit of %s at %h", write ? "write" : "read", addr));
    if (!write) begin
      check(resp_rdata, exp_data, $sformatf("read data at %h", addr));
    end
  endtask

  task automatic reset_read_test();
    check(req_ready, 1'b1, "req_ready after reset");
    check(resp_valid, 1'b0, "resp_valid after reset");
    do_request(1'b0, 32'h0000_0040, '0);
    do_request(1'b0, 32'h0000_0040, '0);
    do_request(1'b0, 32'h0000_004c, '0);
    do_request(1'b0, 32'h0000_03f0, '0);
  endtask

  task automatic write_alloc_test();
    do_request(1'b1, 32'h0000_0120, 32'h1111_0000);
    do_request(1'b0, 32'h0000_0120, '0);
    do_request(1'b0, 32'h0000_0128, '0);
    for (int w = 1; w < 4; w++) begin
      do_request(1'b1, 32'h0000_0120 + 4 * w, 32'h1111_0000 + w);
    end
    for (int w = 0; w < 4; w++) begin
      do_request(1'b0, 32'h0000_0120 + 4 * w, '0);
    end
    // Push the line out and bring it back with a single word write
    do_request(1'b0, 32'h0000_0d20, '0);
    do_request(1'b1, 32'h0000_0124, 32'h2222_0001);
    for (int w = 0; w < 4; w++) begin
      do_request(1'b0, 32'h0000_0120 + 4 * w, '0);
    end
  endtask

  task automatic dirty_evict_test();
    do_request(1'b1, 32'h0000_0230, 32'hcafe_f00d);
    // Same index with another tag
    do_request(1'b0, 32'h0000_0630, '0);
    do_request(1'b0, 32'h0000_0230, '0);
    do_request(1'b0, 32'h0000_0234, '0);
  endtask

  task automatic backpressure_test();
    logic  hit_a;
    logic  hit_b;
    word_t data_a;
    word_t data_b;
    int    cycles;
    // Dirty line in set 0xb makes the next miss there long
    do_request(1'b1, 32'h0000_01b0, 32'h5a5a_0f0f);
    shadow_access(1'b0, 32'h0000_05b0, '0, hit_a, data_a);
    shadow_access(1'b0, 32'h0000_01b0, '0, hit_b, data_b);
    wait_ready();
    req_valid    = 1'b1;
    req_write    = 1'b0;
    req_addr.raw = 32'h0000_05b0;
    next_cycle();
    req_valid = 1'b0;
    next_cycle();
    // Second request raised mid-miss and held
    req_valid    = 1'b1;
    req_addr.raw = 32'h0000_01b0;
    cycles = 0;
    while (!resp_valid) begin
      check(req_ready, 1'b0, "req_ready during a miss");
      next_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("no response to the first request");
      end
    end
    check(resp_hit, hit_a, "resp_hit of the first request");
    check(resp_rdata, data_a, "read data of the first request");
    next_cycle();
    req_valid = 1'b0;
    check(resp_valid, 1'b0, "resp_valid one cycle after a response");
    check(req_ready, 1'b0, "req_ready after the held request is taken");
    wait_response();
    check(resp_hit, hit_b, "resp_hit of the held request");
    check(resp_rdata, data_b, "read data of the held request");
  endtask

  task automatic random_test();
    logic [31:0] rnd;
    logic [31:0] addr;
    logic        write;
    for (int i = 0; i < 200; i++) begin
      rnd   = $random(seed);
      addr  = {21'h0, rnd[10:2], 2'b00};
      write = rnd[31];
      do_request(write, addr, $random(seed));
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Error: watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog timeout");
  end

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_wdata = '0;
    seed      = 32'hea43;
    for (int i = 0; i < 1024; i++) begin
      shadow_mem[i] = '0;
    end
    for (int i = 0; i < `CACHE_NUM_SETS; i++) begin
      shadow_tag[i]   = '0;
      shadow_valid[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_read_test();
    write_alloc_test();
    dirty_evict_test();
    backpressure_test();
    random_test();
    next_cycle();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: files.f
+incdir+.
cache_pkg.sv
cache_arrays.sv
cache_ctrl.sv
line_memory.sv
cache_top.sv
tb_cache.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the failure line
rm -f sim.log
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal --top-module tb_cache \
  -f files.f > build.log 2>&1 &&
  ./obj_dir/Vtb_cache > sim.log 2>&1 ||
  { cat build.log; echo "SIMULATION FAILED" >> sim.log; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
